// File: Bender.yml
package:
  name: mem_frontend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_frontend_pkg.sv
      - hdl/icache.sv
      - hdl/read_arbiter.sv
      - hdl/clint_timer.sv
      - hdl/mem_frontend.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/mem_frontend_properties.sv
      - verification/tb_mem_frontend.sv

// File: hdl/clint_timer.sv
`timescale 1ns/1ns

module clint_timer import mem_frontend_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  t_ar_valid,
    input  addr_t t_ar_addr,
    input  logic  t_r_ready,
    output logic  t_ar_ready,
    output logic  t_r_valid,
    output word_t t_r_data
);

    logic [63:0] mtime;
    logic        rd_pend;
    word_t       rd_word;
    logic        accept;

    assign accept     = t_ar_valid && t_ar_ready;
    assign t_ar_ready = !rd_pend;
    assign t_r_valid  = rd_pend;
    assign t_r_data   = rd_word;

    // Free-running cycle count.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
        end else if (accept) begin
            rd_pend <= 1'b1;
        end else if (t_r_ready) begin
            rd_pend <= 1'b0;
        end
    end

    // Word is taken at acceptance, not at return.
    always_ff @(posedge clock) begin
        if (accept) begin
            rd_word <= t_ar_addr[2] ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

// File: hdl/icache.sv
`timescale 1ns/1ns
`include "mem_frontend_config.svh"

module icache import mem_frontend_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    input  logic  fence_i,
    input  logic  refill_grant,
    input  logic  refill_beat_valid,
    input  word_t refill_beat_data,
    input  logic  refill_last,
    input  logic  refill_err,
    output word_t fetch_data,
    output logic  fetch_fault,
    output logic  fetch_done,
    output logic  refill_req,
    output addr_t refill_addr
);

    icache_state_e state;

    logic [`ICACHE_LINES-1:0] valid;
    tag_t                     tags  [`ICACHE_LINES];
    line_t                    lines [`ICACHE_LINES];

    line_t                    fill_buf;
    line_t                    fill_line;
    logic                     fill_err;
    word_t                    data_q;
    logic                     fault_q;

    index_t                   idx;
    tag_t                     tag;
    logic [WORD_SEL_W-1:0]    word_sel;
    logic                     hit;
    logic                     last_beat;
    logic                     beat_fault;

    assign idx      = fetch_addr[OFFSET_W +: INDEX_W];
    assign tag      = fetch_addr[`ADDR_W-1 -: TAG_W];
    assign word_sel = fetch_addr[BYTE_OFF_W +: WORD_SEL_W];
    assign hit      = valid[idx] && (tags[idx] == tag);

    // Beats arrive lowest word first, so shift in from the top.
    assign fill_line  = {refill_beat_data, fill_buf[$bits(line_t)-1:`DATA_W]};
    assign last_beat  = (state == IC_REFILL_DATA) && refill_beat_valid && refill_last;
    assign beat_fault = fill_err || refill_err;

    assign refill_req  = (state == IC_REFILL_ADDR);
    assign refill_addr = {fetch_addr[`ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign fetch_done  = (state == IC_RESPOND);
    assign fetch_data  = data_q;
    assign fetch_fault = fault_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IC_IDLE;
        end else begin
            case (state)
                IC_IDLE: begin
                    if (fetch_req) begin
                        state <= hit ? IC_RESPOND : IC_REFILL_ADDR;
                    end
                end
                IC_REFILL_ADDR: begin
                    if (refill_grant) begin
                        state <= IC_REFILL_DATA;
                    end
                end
                IC_REFILL_DATA: begin
                    if (last_beat) begin
                        state <= IC_RESPOND;
                    end
                end
                default: begin
                    state <= IC_IDLE; // Done pulse lasts one cycle.
                end
            endcase
        end
    end

    // Sticky error over the beats of one refill.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fill_err <= 1'b0;
        end else if (refill_grant) begin
            fill_err <= 1'b0;
        end else if (refill_beat_valid && refill_err) begin
            fill_err <= 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fence_i) begin
            valid <= '0; // Whole cache at once.
        end else if (last_beat && !beat_fault) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (refill_beat_valid) begin
            fill_buf <= fill_line;
        end
        if (last_beat && !beat_fault) begin
            lines[idx] <= fill_line;
            tags[idx]  <= tag;
        end
        if ((state == IC_IDLE) && fetch_req && hit) begin
            data_q  <= lines[idx][word_sel*`DATA_W +: `DATA_W];
            fault_q <= 1'b0;
        end else if (last_beat) begin
            data_q  <= fill_line[word_sel*`DATA_W +: `DATA_W];
            fault_q <= beat_fault;
        end
    end

endmodule

// File: hdl/mem_frontend.sv
`timescale 1ns/1ns

module mem_frontend import mem_frontend_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       fetch_req,
    input  addr_t      fetch_addr,
    output word_t      fetch_data,
    output logic       fetch_fault,
    output logic       fetch_done,
    input  logic       load_req,
    input  addr_t      load_addr,
    output word_t      load_data,
    output logic       load_fault,
    output logic       load_done,
    input  logic       fence_i,
    output logic       ar_valid,
    input  logic       ar_ready,
    output addr_t      ar_addr,
    output axi_len_t   ar_len,
    output logic [2:0] ar_size,
    output logic [1:0] ar_burst,
    input  logic       r_valid,
    output logic       r_ready,
    input  word_t      r_data,
    input  axi_resp_t  r_resp,
    input  logic       r_last
);

    // Refill link.
    logic  refill_req;
    addr_t refill_addr;
    logic  refill_grant;
    logic  refill_beat_valid;
    word_t refill_beat_data;
    logic  refill_last;
    logic  refill_err;

    // Timer link.
    logic  t_ar_valid;
    logic  t_ar_ready;
    addr_t t_ar_addr;
    logic  t_r_valid;
    logic  t_r_ready;
    word_t t_r_data;

    icache u_icache (
        .clock             (clock),
        .rst_n             (rst_n),
        .fetch_req         (fetch_req),
        .fetch_addr        (fetch_addr),
        .fence_i           (fence_i),
        .refill_grant      (refill_grant),
        .refill_beat_valid (refill_beat_valid),
        .refill_beat_data  (refill_beat_data),
        .refill_last       (refill_last),
        .refill_err        (refill_err),
        .fetch_data        (fetch_data),
        .fetch_fault       (fetch_fault),
        .fetch_done        (fetch_done),
        .refill_req        (refill_req),
        .refill_addr       (refill_addr)
    );

    read_arbiter u_read_arbiter (
        .clock             (clock),
        .rst_n             (rst_n),
        .refill_req        (refill_req),
        .refill_addr       (refill_addr),
        .load_req          (load_req),
        .load_addr         (load_addr),
        .ar_ready          (ar_ready),
        .r_valid           (r_valid),
        .r_data            (r_data),
        .r_resp            (r_resp),
        .r_last            (r_last),
        .t_ar_ready        (t_ar_ready),
        .t_r_valid         (t_r_valid),
        .t_r_data          (t_r_data),
        .refill_grant      (refill_grant),
        .refill_beat_valid (refill_beat_valid),
        .refill_beat_data  (refill_beat_data),
        .refill_last       (refill_last),
        .refill_err        (refill_err),
        .load_data         (load_data),
        .load_fault        (load_fault),
        .load_done         (load_done),
        .ar_valid          (ar_valid),
        .ar_addr           (ar_addr),
        .ar_len            (ar_len),
        .ar_size           (ar_size),
        .ar_burst          (ar_burst),
        .r_ready           (r_ready),
        .t_ar_valid        (t_ar_valid),
        .t_ar_addr         (t_ar_addr),
        .t_r_ready         (t_r_ready)
    );

    clint_timer u_clint_timer (
        .clock      (clock),
        .rst_n      (rst_n),
        .t_ar_valid (t_ar_valid),
        .t_ar_addr  (t_ar_addr),
        .t_r_ready  (t_r_ready),
        .t_ar_ready (t_ar_ready),
        .t_r_valid  (t_r_valid),
        .t_r_data   (t_r_data)
    );

endmodule

// File: hdl/mem_frontend_config.svh
`ifndef MEM_FRONTEND_CONFIG_SVH
`define MEM_FRONTEND_CONFIG_SVH

// Bus widths.
`define ADDR_W          32
`define DATA_W          32

// Instruction cache geometry.
`define ICACHE_LINES    16
`define LINE_BYTES      16
`define BEATS_PER_LINE  4
`define REFILL_LEN      8'd3

// Core-local timer window, 64 KiB.
`define CLINT_BASE      32'h0200_0000
`define CLINT_MASK      32'hFFFF_0000

`define AXI_SIZE_WORD   3'd2
`define AXI_BURST_INCR  2'd1

`endif

// File: hdl/mem_frontend_pkg.sv
`include "mem_frontend_config.svh"

package mem_frontend_pkg;

    localparam int INDEX_W    = $clog2(`ICACHE_LINES);
    localparam int OFFSET_W   = $clog2(`LINE_BYTES);
    localparam int TAG_W      = `ADDR_W - INDEX_W - OFFSET_W;
    localparam int BYTE_OFF_W = $clog2(`DATA_W / 8);
    localparam int WORD_SEL_W = $clog2(`BEATS_PER_LINE);

    typedef logic [`ADDR_W-1:0]                 addr_t;
    typedef logic [`DATA_W-1:0]                 word_t;
    typedef logic [`BEATS_PER_LINE*`DATA_W-1:0] line_t;
    typedef logic [TAG_W-1:0]                   tag_t;
    typedef logic [INDEX_W-1:0]                 index_t;
    typedef logic [7:0]                         axi_len_t;
    typedef logic [1:0]                         axi_resp_t;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_REFILL_ADDR,
        IC_REFILL_DATA,
        IC_RESPOND
    } icache_state_e;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_REFILL,
        OWN_LOAD
    } arb_owner_e;

    typedef enum logic {
        TGT_EXTERNAL,
        TGT_TIMER
    } rd_target_e;

endpackage

// File: hdl/read_arbiter.sv
`timescale 1ns/1ns
`include "mem_frontend_config.svh"

module read_arbiter import mem_frontend_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      refill_req,
    input  addr_t     refill_addr,
    input  logic      load_req,
    input  addr_t     load_addr,
    input  logic      ar_ready,
    input  logic      r_valid,
    input  word_t     r_data,
    input  axi_resp_t r_resp,
    input  logic      r_last,
    input  logic      t_ar_ready,
    input  logic      t_r_valid,
    input  word_t     t_r_data,
    output logic      refill_grant,
    output logic      refill_beat_valid,
    output word_t     refill_beat_data,
    output logic      refill_last,
    output logic      refill_err,
    output word_t     load_data,
    output logic      load_fault,
    output logic      load_done,
    output logic      ar_valid,
    output addr_t     ar_addr,
    output axi_len_t  ar_len,
    output logic [2:0] ar_size,
    output logic [1:0] ar_burst,
    output logic      r_ready,
    output logic      t_ar_valid,
    output addr_t     t_ar_addr,
    output logic      t_r_ready
);

    arb_owner_e owner;
    rd_target_e target;
    logic       addr_pend;   // Address channel still waiting for ready.
    addr_t      addr_q;
    word_t      load_data_q;
    logic       load_fault_q;
    logic       load_done_q;

    logic       load_is_timer;
    logic       load_go;
    logic       refill_go;
    logic       ar_hs;
    logic       t_ar_hs;
    logic       r_hs;
    logic       t_r_hs;
    logic       load_end;

    assign load_is_timer = ((load_addr & `CLINT_MASK) == `CLINT_BASE);

    // Load has priority. Skip the cycle in which its done pulse is out.
    assign load_go   = (owner == OWN_NONE) && load_req && !load_done_q;
    assign refill_go = (owner == OWN_NONE) && refill_req && !load_go;

    assign ar_valid = addr_pend && (target == TGT_EXTERNAL);
    assign ar_addr  = addr_q;
    assign ar_len   = (owner == OWN_REFILL) ? `REFILL_LEN : '0;
    assign ar_size  = `AXI_SIZE_WORD;
    assign ar_burst = `AXI_BURST_INCR;
    assign r_ready  = (owner != OWN_NONE) && !addr_pend && (target == TGT_EXTERNAL);

    assign t_ar_valid = addr_pend && (target == TGT_TIMER);
    assign t_ar_addr  = addr_q;
    assign t_r_ready  = (owner == OWN_LOAD) && !addr_pend && (target == TGT_TIMER);

    assign ar_hs   = ar_valid && ar_ready;
    assign t_ar_hs = t_ar_valid && t_ar_ready;
    assign r_hs    = r_valid && r_ready;
    assign t_r_hs  = t_r_valid && t_r_ready;

    assign refill_grant      = ar_hs && (owner == OWN_REFILL);
    assign refill_beat_valid = r_hs && (owner == OWN_REFILL);
    assign refill_beat_data  = r_data;
    assign refill_last       = refill_beat_valid && r_last;
    assign refill_err        = refill_beat_valid && (r_resp != '0);

    assign load_end = (owner == OWN_LOAD) && ((r_hs && r_last) || t_r_hs);

    assign load_data  = load_data_q;
    assign load_fault = load_fault_q;
    assign load_done  = load_done_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            owner       <= OWN_NONE;
            target      <= TGT_EXTERNAL;
            addr_pend   <= 1'b0;
            load_done_q <= 1'b0;
        end else begin
            load_done_q <= load_end;
            if (load_go) begin
                owner     <= OWN_LOAD;
                target    <= load_is_timer ? TGT_TIMER : TGT_EXTERNAL;
                addr_pend <= 1'b1;
            end else if (refill_go) begin
                owner     <= OWN_REFILL;
                target    <= TGT_EXTERNAL;
                addr_pend <= 1'b1;
            end else begin
                if (ar_hs || t_ar_hs) begin
                    addr_pend <= 1'b0;
                end
                if (load_end || refill_last) begin
                    owner <= OWN_NONE; // Bus free after the last beat.
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_go) begin
            addr_q <= load_addr;
        end else if (refill_go) begin
            addr_q <= refill_addr;
        end
        if (load_end) begin
            load_data_q  <= t_r_hs ? t_r_data : r_data;
            load_fault_q <= !t_r_hs && (r_resp != '0); // Timer never faults.
        end
    end

endmodule

// File: mem_frontend.f
+incdir+hdl
hdl/mem_frontend_pkg.sv
hdl/icache.sv
hdl/read_arbiter.sv
hdl/clint_timer.sv
hdl/mem_frontend.sv
verification/mem_frontend_properties.sv
verification/tb_mem_frontend.sv

// File: verification/mem_frontend_properties.sv
`timescale 1ns/1ns

module mem_frontend_properties import mem_frontend_pkg::*; (
    input logic     clock,
    input logic     rst_n,
    input logic     ar_valid,
    input logic     ar_ready,
    input addr_t    ar_addr,
    input axi_len_t ar_len,
    input logic     r_ready,
    input logic     fetch_done,
    input logic     load_done,
    input logic     refill_grant,
    input logic     refill_last
);

    int   fail_count = 0;
    logic refill_active; // Refill burst between grant and last beat.

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            refill_active <= 1'b0;
        end else if (refill_grant) begin
            refill_active <= 1'b1;
        end else if (refill_last) begin
            refill_active <= 1'b0;
        end
    end

    // Address fields hold while the slave stalls.
    ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
    else begin
        fail_count++;
        $error("ar fields changed while ar_valid waited for ar_ready");
    end

    // No load may finish while a refill holds the bus.
    grant_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
        (refill_grant || refill_active) |-> !load_done)
    else begin
        fail_count++;
        $error("refill and load owned the read channel at the same time");
    end

    // Control outputs quiet while reset is held.
    reset_quiet: assert property (@(posedge clock)
        !rst_n |-> !fetch_done && !load_done && !ar_valid && !r_ready)
    else begin
        fail_count++;
        $error("control output high during reset");
    end

endmodule

// File: verification/tb_mem_frontend.sv
`timescale 1ns/1ns
`include "mem_frontend_config.svh"

module tb_mem_frontend import mem_frontend_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int OP_CYCLES    = 200; // Worst case per operation.
    localparam int N_FETCH      = 40;
    localparam int N_REFETCH    = 8;
    localparam int N_LOAD       = 12;
    localparam int N_TIMER      = 8;
    localparam int N_MIXED      = 30;
    localparam int N_OPS        = N_FETCH + N_REFETCH + 3 + N_LOAD + N_TIMER + 2 * N_MIXED;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + N_OPS * OP_CYCLES) * CLK_PERIOD;

    logic      clock = 1'b0;
    logic      rst_n;
    logic      fetch_req;
    addr_t     fetch_addr;
    word_t     fetch_data;
    logic      fetch_fault;
    logic      fetch_done;
    logic      load_req;
    addr_t     load_addr;
    word_t     load_data;
    logic      load_fault;
    logic      load_done;
    logic      fence_i;
    logic      ar_valid;
    logic      ar_ready;
    addr_t     ar_addr;
    axi_len_t  ar_len;
    logic [2:0] ar_size;
    logic [1:0] ar_burst;
    logic      r_valid;
    logic      r_ready;
    word_t     r_data;
    axi_resp_t r_resp;
    logic      r_last;

    int          n_checks = 0;
    int          n_errors = 0;
    int          n_burst  = 0; // Length 3 address handshakes.
    int          n_single = 0; // Length 0 address handshakes.
    int unsigned cycle_count = 0;

    logic [`ICACHE_LINES-1:0] model_valid = '0;
    tag_t                     model_tag [`ICACHE_LINES];

    // Memory model state.
    logic  mem_busy = 1'b0;
    addr_t beat_addr;
    int    beats_left;

    mem_frontend i_mem_frontend (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_fault (fetch_fault),
        .fetch_done  (fetch_done),
        .load_req    (load_req),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .load_fault  (load_fault),
        .load_done   (load_done),
        .fence_i     (fence_i),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar_addr     (ar_addr),
        .ar_len      (ar_len),
        .ar_size     (ar_size),
        .ar_burst    (ar_burst),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r_data      (r_data),
        .r_resp      (r_resp),
        .r_last      (r_last)
    );

    bind mem_frontend mem_frontend_properties u_props (
        .clock        (clock),
        .rst_n        (rst_n),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .ar_addr      (ar_addr),
        .ar_len       (ar_len),
        .r_ready      (r_ready),
        .fetch_done   (fetch_done),
        .load_done    (load_done),
        .refill_grant (refill_grant),
        .refill_last  (refill_last)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) cycle_count <= cycle_count + 1;

    // Word address folded with a fixed pattern.
    function automatic word_t mem_word(input addr_t addr);
        return (addr >> 2) ^ 32'h5a5a_0000;
    endfunction

    function automatic addr_t random_fetch_addr(input int n_tags);
        return 32'h0001_0000 | (($urandom % n_tags) << 8) | (($urandom % 16) << 4)
             | (($urandom % 4) << 2);
    endfunction

    // Outside the timer window; a quarter of them fault.
    function automatic addr_t random_ext_addr();
        return ($urandom & 32'h00FF_FFFC)
             | ((($urandom % 4) == 0) ? 32'h8000_0000 : 32'h1000_0000);
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // AXI read slave with random stalls.
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            r_resp   <= '0;
            r_last   <= 1'b0;
            mem_busy = 1'b0;
        end else begin
            if (r_valid && r_ready) begin
                beats_left--;
                beat_addr = beat_addr + 4;
            end
            if (mem_busy && (beats_left == 0)) begin
                mem_busy = 1'b0;
            end
            if (!mem_busy) begin
                r_valid <= 1'b0;
                r_last  <= 1'b0;
                if (ar_valid && ar_ready) begin
                    compare("ar size", 3'd2, ar_size); // One word per beat.
                    compare("ar burst", 2'b01, ar_burst); // Incrementing.
                    if (ar_len == 8'd3) n_burst++;
                    else if (ar_len == 8'd0) n_single++;
                    beat_addr  = ar_addr;
                    beats_left = ar_len + 1;
                    mem_busy   = 1'b1;
                    ar_ready <= 1'b0;
                end else begin
                    ar_ready <= ($urandom % 4) != 0;
                end
            end
            if (mem_busy && !(r_valid && !r_ready)) begin
                if (($urandom % 3) != 0) begin
                    r_valid <= 1'b1;
                    r_data  <= mem_word(beat_addr);
                    r_resp  <= beat_addr[31] ? 2'b10 : 2'b00; // SLVERR.
                    r_last  <= (beats_left == 1);
                end else begin
                    r_valid <= 1'b0;
                    r_last  <= 1'b0;
                end
            end
        end
    end

    task automatic fetch_word(input addr_t addr, input string name);
        index_t idx;
        logic   miss;
        int     bursts_before;
        int     waits;
        idx           = addr[7:4];
        miss          = !(model_valid[idx] && (model_tag[idx] == addr[31:8]));
        bursts_before = n_burst;
        waits         = 0;
        @(posedge clock);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        do begin
            @(posedge clock);
            waits++;
        end while (!fetch_done);
        fetch_req <= 1'b0;
        compare({name, " fault"}, addr[31], fetch_fault);
        if (!addr[31]) compare({name, " data"}, mem_word(addr), fetch_data);
        compare({name, " refills"}, miss, n_burst - bursts_before);
        if (!miss) compare({name, " hit latency"}, 2, waits);
        if (miss && !addr[31]) begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = addr[31:8];
        end
    endtask

    task automatic load_word(input addr_t addr, output word_t data, output logic fault,
                             output int unsigned req_cycle);
        @(posedge clock);
        load_req  <= 1'b1;
        load_addr <= addr;
        req_cycle = cycle_count;
        do @(posedge clock); while (!load_done);
        load_req <= 1'b0;
        data  = load_data;
        fault = load_fault;
    endtask

    task automatic pulse_fence();
        @(posedge clock);
        fence_i <= 1'b1;
        @(posedge clock);
        fence_i <= 1'b0;
        model_valid = '0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        addr_t       first_addrs [N_REFETCH];
        addr_t       addr;
        word_t       data;
        word_t       lo;
        word_t       hi;
        word_t       lo2;
        logic        fault;
        logic [63:0] prev_time;
        int unsigned c1;
        int unsigned c2;
        int          singles_before;
        int          bursts_before;
        int          total_errors;

        void'($urandom(32'hc04d2ff1));
        rst_n      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        load_req   = 1'b0;
        load_addr  = '0;
        fence_i    = 1'b0;
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r_data     = '0;
        r_resp     = '0;
        r_last     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;

        for (int i = 0; i < N_FETCH; i++) begin
            addr = random_fetch_addr(4);
            if (i < N_REFETCH) first_addrs[i] = addr;
            fetch_word(addr, "fetch");
        end

        pulse_fence();
        for (int i = 0; i < N_REFETCH; i++) begin
            fetch_word(first_addrs[i], "fetch after fence");
        end

        // Faulting line stays uncached.
        fetch_word(32'h8000_0040, "fault fetch");
        fetch_word(32'h8000_0040, "fault refetch");

        for (int i = 0; i < N_LOAD; i++) begin
            addr = (i == 0) ? 32'h8000_0100 : random_ext_addr();
            singles_before = n_single;
            load_word(addr, data, fault, c1);
            compare("load fault", addr[31], fault);
            if (!addr[31]) compare("load data", mem_word(addr), data);
            compare("load single beat", 1, n_single - singles_before);
        end

        singles_before = n_single;
        bursts_before  = n_burst;
        prev_time      = '0;
        for (int i = 0; i < 3; i++) begin
            load_word(`CLINT_BASE, lo, fault, c1);
            compare("timer low fault", 0, fault);
            load_word(`CLINT_BASE + 4, hi, fault, c1);
            compare("timer high fault", 0, fault);
            compare("timer increasing", 1, {hi, lo} > prev_time);
            prev_time = {hi, lo};
        end
        load_word(`CLINT_BASE, lo, fault, c1);
        load_word(`CLINT_BASE, lo2, fault, c2);
        compare("timer low delta", 1, (lo2 - lo) >= (c2 - c1));
        compare("timer bus handshakes", 0,
                (n_single - singles_before) + (n_burst - bursts_before));

        fork
            begin
                for (int k = 0; k < N_MIXED; k++) begin
                    fetch_word(random_fetch_addr(8), "mixed fetch");
                end
            end
            begin
                addr_t       m_addr;
                word_t       m_data;
                logic        m_fault;
                int unsigned m_cycle;
                for (int k = 0; k < N_MIXED; k++) begin
                    if (($urandom % 3) == 0) begin
                        m_addr = `CLINT_BASE | (($urandom % 2) << 2);
                    end else begin
                        m_addr = random_ext_addr();
                    end
                    load_word(m_addr, m_data, m_fault, m_cycle);
                    compare("mixed load fault", m_addr[31], m_fault);
                    if (m_addr[31:24] == 8'h10) begin
                        compare("mixed load data", mem_word(m_addr), m_data);
                    end
                end
            end
        join

        repeat (5) @(posedge clock);
        total_errors = n_errors + i_mem_frontend.u_props.fail_count;
        $display("Checks run: %0d, mismatches: %0d, assertion failures: %0d",
                 n_checks, n_errors, i_mem_frontend.u_props.fail_count);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
